// ==== verilog/bf16_pkg.sv ====
package bf16_pkg;

  localparam int OP_W     = 4;    // Opcode field width
  localparam int EXP_BIAS = 127;
  localparam int EXP_MAX  = 255;  // All-ones exponent for infinity
  localparam int SIG_W    = 16;   // Working significand with hidden one at the top

  typedef logic [OP_W-1:0] op_t;

  localparam op_t OP_ADD    = op_t'(1);
  localparam op_t OP_SUB    = op_t'(2);
  localparam op_t OP_MUL    = op_t'(3);
  localparam op_t OP_RAM_RD = op_t'(5);
  localparam op_t OP_RAM_WR = op_t'(6);
  localparam op_t OP_SD_RD  = op_t'(7);
  localparam op_t OP_SD_WR  = op_t'(8);

  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [6:0] frac;
  } bf16_fields_t;

  // Same word seen as raw bits or as bfloat16 fields
  typedef union packed {
    logic [15:0]  raw;
    bf16_fields_t f;
  } bf16_t;

endpackage

// ==== verilog/bf16_arith_pipe.sv ====
`timescale 1ns/1ns

module bf16_arith_pipe (
  input  logic            clk,
  input  logic            rst,
  input  logic            issue_valid,
  input  bf16_pkg::op_t   issue_op,
  input  bf16_pkg::bf16_t issue_a,
  input  bf16_pkg::bf16_t issue_b,
  output logic            res_valid,
  output bf16_pkg::bf16_t res_data
);

  localparam int SW = bf16_pkg::SIG_W;
  localparam int EW = 10;  // Signed exponent, room for mul sums

  logic [SW-1:0]        sig_a;
  logic [SW-1:0]        sig_b;
  logic [SW-1:0]        big_sig;
  logic [SW-1:0]        small_sig;
  logic [7:0]           big_exp;
  logic                 big_sign;
  logic                 small_sign;
  logic                 eff_sign_b;
  logic [SW:0]          sum_mag;
  logic                 sum_sign;
  logic [15:0]          prod;
  logic                 c_sign;
  logic signed [EW-1:0] c_exp;
  logic [SW:0]          c_mag;

  logic                 s1_valid;
  logic                 s1_sign;
  logic signed [EW-1:0] s1_exp;
  logic [SW:0]          s1_mag;   // Bit SW is the carry, binary point below it

  logic [4:0]           lz;
  logic [SW-1:0]        norm_sig;
  logic signed [EW-1:0] norm_exp;
  bf16_pkg::bf16_t      packed_res;

  // Zero exponent field means zero operand
  assign sig_a = (issue_a.f.exp != 8'd0) ? {1'b1, issue_a.f.frac, {(SW-8){1'b0}}} : '0;
  assign sig_b = (issue_b.f.exp != 8'd0) ? {1'b1, issue_b.f.frac, {(SW-8){1'b0}}} : '0;
  assign prod  = sig_a[SW-1 -: 8] * sig_b[SW-1 -: 8];

  always_comb begin
    eff_sign_b = issue_b.f.sign ^ (issue_op == bf16_pkg::OP_SUB);
    if (issue_a.f.exp >= issue_b.f.exp) begin
      big_exp    = issue_a.f.exp;
      big_sig    = sig_a;
      big_sign   = issue_a.f.sign;
      small_sig  = sig_b >> (issue_a.f.exp - issue_b.f.exp);  // Shifted-out bits dropped
      small_sign = eff_sign_b;
    end else begin
      big_exp    = issue_b.f.exp;
      big_sig    = sig_b;
      big_sign   = eff_sign_b;
      small_sig  = sig_a >> (issue_b.f.exp - issue_a.f.exp);
      small_sign = issue_a.f.sign;
    end
    if (big_sign == small_sign) begin
      sum_mag  = {1'b0, big_sig} + {1'b0, small_sig};
      sum_sign = big_sign;
    end else if (big_sig >= small_sig) begin
      sum_mag  = {1'b0, big_sig - small_sig};
      sum_sign = big_sign;
    end else begin
      sum_mag  = {1'b0, small_sig - big_sig};
      sum_sign = small_sign;
    end
    if (sum_mag == '0) begin
      sum_sign = 1'b0;  // Exact cancellation is +0
    end
    if (issue_op == bf16_pkg::OP_MUL) begin
      c_sign = issue_a.f.sign ^ issue_b.f.sign;
      c_exp  = EW'(issue_a.f.exp) + EW'(issue_b.f.exp) - EW'(bf16_pkg::EXP_BIAS);
      c_mag  = {prod, 1'b0};  // 2.14 product lined up with the adder format
    end else begin
      c_sign = sum_sign;
      c_exp  = EW'(big_exp);
      c_mag  = sum_mag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
    s1_sign <= c_sign;
    s1_exp  <= c_exp;
    s1_mag  <= c_mag;
  end

  always_comb begin
    lz = '0;
    for (int i = 0; i < SW; i++) begin
      if (s1_mag[i]) begin
        lz = 5'(SW - 1 - i);  // Highest set bit wins
      end
    end
    if (s1_mag[SW]) begin
      norm_sig = s1_mag[SW:1];
      norm_exp = s1_exp + EW'(1);
    end else begin
      norm_sig = s1_mag[SW-1:0] << lz;
      norm_exp = s1_exp - EW'(lz);
    end
    packed_res.f.sign = s1_sign;
    if (s1_mag == '0 || norm_exp < 1) begin
      packed_res.f.exp  = 8'd0;  // Signed zero
      packed_res.f.frac = 7'd0;
    end else if (norm_exp > bf16_pkg::EXP_MAX - 1) begin
      packed_res.f.exp  = 8'(bf16_pkg::EXP_MAX);  // Signed infinity
      packed_res.f.frac = 7'd0;
    end else begin
      packed_res.f.exp  = norm_exp[7:0];
      packed_res.f.frac = norm_sig[SW-2 -: 7];  // Truncate below 7 fraction bits
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
    res_data <= packed_res;
  end

endmodule

// ==== verilog/bf16_arith_path.sv ====
`timescale 1ns/1ns

module bf16_arith_path #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            host_req,
  input  bf16_pkg::op_t   host_opcode,
  input  bf16_pkg::bf16_t host_data_a,
  input  bf16_pkg::bf16_t host_data_b,
  input  logic            mem_busy,
  output logic            arith_accept,
  output logic            arith_idle,
  output logic            queue_full,
  output logic            arith_res_valid,
  output bf16_pkg::bf16_t arith_res_data
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  bf16_pkg::op_t    q_op [QUEUE_DEPTH];
  bf16_pkg::bf16_t  q_a  [QUEUE_DEPTH];
  bf16_pkg::bf16_t  q_b  [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [1:0]       in_flight;  // Ops inside the two pipeline stages
  logic             accept_q;
  logic             is_arith;
  logic             issue_valid;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign is_arith = host_opcode inside {bf16_pkg::OP_ADD, bf16_pkg::OP_SUB, bf16_pkg::OP_MUL};
  assign queue_full  = (count == CNT_W'(QUEUE_DEPTH));
  assign issue_valid = (count != '0);  // Head goes out every cycle
  // Request is still held during its ack cycle, so skip that cycle
  assign arith_accept = host_req && is_arith && !queue_full && !mem_busy && !accept_q;
  assign arith_idle   = (count == '0) && (in_flight == 2'd0);

  always_ff @(posedge clk) begin
    if (arith_accept) begin
      q_op[wr_ptr] <= host_opcode;
      q_a[wr_ptr]  <= host_data_a;
      q_b[wr_ptr]  <= host_data_b;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_flight <= 2'd0;
      accept_q  <= 1'b0;
    end else begin
      accept_q <= arith_accept;
      if (arith_accept) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (issue_valid) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count     <= count + CNT_W'(arith_accept) - CNT_W'(issue_valid);
      in_flight <= in_flight + 2'(issue_valid) - 2'(arith_res_valid);
    end
  end

  bf16_arith_pipe pipe_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (q_op[rd_ptr]),
    .issue_a     (q_a[rd_ptr]),
    .issue_b     (q_b[rd_ptr]),
    .res_valid   (arith_res_valid),
    .res_data    (arith_res_data)
  );

endmodule

// ==== verilog/mem_access.sv ====
`timescale 1ns/1ns

module mem_access #(
  parameter int RAM_ADDR_W   = 10,
  parameter int SDRAM_ADDR_W = 24
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    host_req,
  input  bf16_pkg::op_t           host_opcode,
  input  bf16_pkg::bf16_t         host_data_a,
  input  logic [RAM_ADDR_W-1:0]   host_ram_addr,
  input  logic [SDRAM_ADDR_W-1:0] host_sdram_addr,
  input  logic [15:0]             host_sdram_data,
  input  logic                    arith_idle,
  output logic [RAM_ADDR_W-1:0]   ram_addr,
  output logic                    ram_we,
  output logic [15:0]             ram_wdata,
  input  logic [15:0]             ram_rdata,
  output logic                    sdram_req,
  output logic                    sdram_wr,
  output logic [SDRAM_ADDR_W-1:0] sdram_addr,
  output logic [15:0]             sdram_wdata,
  input  logic                    sdram_ack,
  input  logic [15:0]             sdram_rdata,
  output logic                    mem_accept,
  output logic                    mem_busy,
  output logic                    mem_res_valid,
  output logic [15:0]             mem_res_data,
  output logic                    mem_res_status
);

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_RAM_ADR = 3'd1;
  localparam logic [2:0] ST_RAM_DAT = 3'd2;
  localparam logic [2:0] ST_SD_WAIT = 3'd3;
  localparam logic [2:0] ST_DONE    = 3'd4;

  logic [2:0]  state;
  logic        is_arith;
  logic [15:0] res_data_q;
  logic        res_status_q;

  assign is_arith = host_opcode inside {bf16_pkg::OP_ADD, bf16_pkg::OP_SUB, bf16_pkg::OP_MUL};
  assign mem_accept     = host_req && !is_arith && arith_idle && (state == ST_IDLE);
  assign mem_busy       = (state != ST_IDLE);
  assign mem_res_valid  = (state == ST_RAM_DAT) || (state == ST_DONE);
  assign mem_res_data   = (state == ST_RAM_DAT) ? ram_rdata : res_data_q;  // RAM read passes through
  assign mem_res_status = (state == ST_DONE) && res_status_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      ram_we    <= 1'b0;
      sdram_req <= 1'b0;
      sdram_wr  <= 1'b0;
    end else begin
      ram_we <= 1'b0;  // One-cycle write strobe
      case (state)
        ST_IDLE: begin
          if (mem_accept) begin
            res_data_q   <= '0;  // Writes answer with zero data
            res_status_q <= 1'b0;
            case (host_opcode)
              bf16_pkg::OP_RAM_RD: begin
                ram_addr <= host_ram_addr;
                state    <= ST_RAM_ADR;
              end
              bf16_pkg::OP_RAM_WR: begin
                ram_addr  <= host_ram_addr;
                ram_wdata <= host_data_a.raw;
                ram_we    <= 1'b1;
                state     <= ST_DONE;
              end
              bf16_pkg::OP_SD_RD, bf16_pkg::OP_SD_WR: begin
                sdram_addr  <= host_sdram_addr;
                sdram_wdata <= host_sdram_data;
                sdram_wr    <= (host_opcode == bf16_pkg::OP_SD_WR);
                sdram_req   <= 1'b1;
                state       <= ST_SD_WAIT;
              end
              default: begin
                res_status_q <= 1'b1;  // Unknown opcode
                state        <= ST_DONE;
              end
            endcase
          end
        end
        ST_RAM_ADR: begin
          state <= ST_RAM_DAT;  // RAM samples the address here
        end
        ST_SD_WAIT: begin
          if (sdram_ack) begin
            sdram_req <= 1'b0;
            if (!sdram_wr) begin
              res_data_q <= sdram_rdata;
            end
            state <= ST_DONE;
          end
        end
        default: begin
          state <= ST_IDLE;  // RAM_DAT and DONE report for one cycle
        end
      endcase
    end
  end

endmodule

// ==== verilog/host_response.sv ====
`timescale 1ns/1ns

module host_response (
  input  logic            clk,
  input  logic            rst,
  input  logic            arith_accept,
  input  logic            mem_accept,
  input  logic            queue_full,
  input  logic            mem_busy,
  input  logic            arith_res_valid,
  input  bf16_pkg::bf16_t arith_res_data,
  input  logic            mem_res_valid,
  input  logic [15:0]     mem_res_data,
  input  logic            mem_res_status,
  output logic            host_ack,
  output logic            host_busy,
  output logic            host_resp_valid,
  output bf16_pkg::bf16_t host_data_out,
  output logic            host_op_status
);

  always_ff @(posedge clk) begin
    if (rst) begin
      host_ack        <= 1'b0;
      host_busy       <= 1'b0;
      host_resp_valid <= 1'b0;
    end else begin
      host_ack        <= arith_accept | mem_accept;
      host_busy       <= queue_full | mem_busy;
      host_resp_valid <= arith_res_valid | mem_res_valid;  // Paths never finish together
    end
  end

  always_ff @(posedge clk) begin
    if (arith_res_valid) begin
      host_data_out  <= arith_res_data;
      host_op_status <= 1'b0;
    end else if (mem_res_valid) begin
      host_data_out.raw <= mem_res_data;
      host_op_status    <= mem_res_status;
    end
  end

endmodule

// ==== verilog/bf16_processor.sv ====
`timescale 1ns/1ns

module bf16_processor #(
  parameter int RAM_ADDR_W   = 10,
  parameter int SDRAM_ADDR_W = 24,
  parameter int QUEUE_DEPTH  = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    host_req,
  input  bf16_pkg::op_t           host_opcode,
  input  bf16_pkg::bf16_t         host_data_a,
  input  bf16_pkg::bf16_t         host_data_b,
  input  logic [RAM_ADDR_W-1:0]   host_ram_addr,
  input  logic [SDRAM_ADDR_W-1:0] host_sdram_addr,
  input  logic [15:0]             host_sdram_data,
  output logic                    host_ack,
  output logic                    host_busy,
  output logic                    host_resp_valid,
  output bf16_pkg::bf16_t         host_data_out,
  output logic                    host_op_status,
  output logic [RAM_ADDR_W-1:0]   ram_addr,
  output logic                    ram_we,
  output logic [15:0]             ram_wdata,
  input  logic [15:0]             ram_rdata,
  output logic                    sdram_req,
  output logic                    sdram_wr,
  output logic [SDRAM_ADDR_W-1:0] sdram_addr,
  output logic [15:0]             sdram_wdata,
  input  logic                    sdram_ack,
  input  logic [15:0]             sdram_rdata
);

  logic            arith_accept;
  logic            arith_idle;
  logic            queue_full;
  logic            arith_res_valid;
  bf16_pkg::bf16_t arith_res_data;
  logic            mem_accept;
  logic            mem_busy;
  logic            mem_res_valid;
  logic [15:0]     mem_res_data;
  logic            mem_res_status;

  bf16_arith_path #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) arith_i (
    .clk             (clk),
    .rst             (rst),
    .host_req        (host_req),
    .host_opcode     (host_opcode),
    .host_data_a     (host_data_a),
    .host_data_b     (host_data_b),
    .mem_busy        (mem_busy),
    .arith_accept    (arith_accept),
    .arith_idle      (arith_idle),
    .queue_full      (queue_full),
    .arith_res_valid (arith_res_valid),
    .arith_res_data  (arith_res_data)
  );

  mem_access #(
    .RAM_ADDR_W   (RAM_ADDR_W),
    .SDRAM_ADDR_W (SDRAM_ADDR_W)
  ) mem_i (
    .clk             (clk),
    .rst             (rst),
    .host_req        (host_req),
    .host_opcode     (host_opcode),
    .host_data_a     (host_data_a),
    .host_ram_addr   (host_ram_addr),
    .host_sdram_addr (host_sdram_addr),
    .host_sdram_data (host_sdram_data),
    .arith_idle      (arith_idle),
    .ram_addr        (ram_addr),
    .ram_we          (ram_we),
    .ram_wdata       (ram_wdata),
    .ram_rdata       (ram_rdata),
    .sdram_req       (sdram_req),
    .sdram_wr        (sdram_wr),
    .sdram_addr      (sdram_addr),
    .sdram_wdata     (sdram_wdata),
    .sdram_ack       (sdram_ack),
    .sdram_rdata     (sdram_rdata),
    .mem_accept      (mem_accept),
    .mem_busy        (mem_busy),
    .mem_res_valid   (mem_res_valid),
    .mem_res_data    (mem_res_data),
    .mem_res_status  (mem_res_status)
  );

  host_response resp_i (
    .clk             (clk),
    .rst             (rst),
    .arith_accept    (arith_accept),
    .mem_accept      (mem_accept),
    .queue_full      (queue_full),
    .mem_busy        (mem_busy),
    .arith_res_valid (arith_res_valid),
    .arith_res_data  (arith_res_data),
    .mem_res_valid   (mem_res_valid),
    .mem_res_data    (mem_res_data),
    .mem_res_status  (mem_res_status),
    .host_ack        (host_ack),
    .host_busy       (host_busy),
    .host_resp_valid (host_resp_valid),
    .host_data_out   (host_data_out),
    .host_op_status  (host_op_status)
  );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

// ==== dv/bf16_processor_assert.sv ====
`timescale 1ns/1ns

module bf16_processor_assert (
  input logic clk,
  input logic rst,
  input logic host_req,
  input logic host_ack,
  input logic ram_we,
  input logic sdram_req,
  input logic sdram_ack,
  input logic arith_res_valid,
  input logic mem_res_valid
);

  sdram_hold: assert property (@(posedge clk) disable iff (rst)
    sdram_req && !sdram_ack |=> sdram_req)
    else $error("sdram_req dropped before sdram_ack");

  ram_we_pulse: assert property (@(posedge clk) disable iff (rst) ram_we |=> !ram_we)
    else $error("ram_we high for two cycles");

  // Ack is registered, so the request was there one edge earlier
  ack_needs_req: assert property (@(posedge clk) disable iff (rst) host_ack |-> $past(host_req))
    else $error("host_ack without host_req");

  one_result: assert property (@(posedge clk) disable iff (rst)
    !(arith_res_valid && mem_res_valid))
    else $error("arithmetic and memory results in the same cycle");

endmodule

bind bf16_processor bf16_processor_assert assert_i (
  .clk             (clk),
  .rst             (rst),
  .host_req        (host_req),
  .host_ack        (host_ack),
  .ram_we          (ram_we),
  .sdram_req       (sdram_req),
  .sdram_ack       (sdram_ack),
  .arith_res_valid (arith_res_valid),
  .mem_res_valid   (mem_res_valid)
);

// ==== dv/bf16_processor_tb.sv ====
`timescale 1ns/1ns

module bf16_processor_tb;

  localparam int RAM_ADDR_W   = 10;
  localparam int SDRAM_ADDR_W = 24;
  localparam int QUEUE_DEPTH  = 4;
  localparam int N_ADDSUB     = 40;
  localparam int N_MUL        = 30;
  localparam int N_RAM        = 4;
  localparam int N_SD         = 6;
  localparam int TOTAL_REQS   = N_ADDSUB + 3 + N_MUL + 5 + QUEUE_DEPTH + 2
                                + 2 * N_RAM + 1 + 2 * N_SD + 1 + 4;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 200 + 1000;

  logic                    clk;
  logic                    rst;
  logic                    host_req;
  bf16_pkg::op_t           host_opcode;
  bf16_pkg::bf16_t         host_data_a;
  bf16_pkg::bf16_t         host_data_b;
  logic [RAM_ADDR_W-1:0]   host_ram_addr;
  logic [SDRAM_ADDR_W-1:0] host_sdram_addr;
  logic [15:0]             host_sdram_data;
  logic                    host_ack;
  logic                    host_busy;
  logic                    host_resp_valid;
  bf16_pkg::bf16_t         host_data_out;
  logic                    host_op_status;
  logic [RAM_ADDR_W-1:0]   ram_addr;
  logic                    ram_we;
  logic [15:0]             ram_wdata;
  logic [15:0]             ram_rdata = '0;
  logic                    sdram_req;
  logic                    sdram_wr;
  logic [SDRAM_ADDR_W-1:0] sdram_addr;
  logic [15:0]             sdram_wdata;
  logic                    sdram_ack = 1'b0;
  logic [15:0]             sdram_rdata = '0;

  bf16_pkg::bf16_t exp_data_q[$];  // Expected results in request order
  logic            exp_status_q[$];
  logic            exp_busy_q[$];  // Memory request still open when it responds
  logic [15:0]     ram_mem [logic [RAM_ADDR_W-1:0]];
  logic [15:0]     sd_mem [logic [SDRAM_ADDR_W-1:0]];
  int              sd_delay = 0;
  int              err_count = 0;
  int              check_count = 0;
  int              n_tests = 0;
  int              test_err_base = 0;

  tb_clock #(.PERIOD(20)) clk_i (.clk(clk));

  bf16_processor #(
    .RAM_ADDR_W   (RAM_ADDR_W),
    .SDRAM_ADDR_W (SDRAM_ADDR_W),
    .QUEUE_DEPTH  (QUEUE_DEPTH)
  ) dut_i (.*);

  function automatic logic [15:0] ram_fill(input logic [RAM_ADDR_W-1:0] a);
    ram_fill = 16'(int'(a) * 32'h9E37) ^ 16'h5A5A;
  endfunction

  function automatic logic [15:0] sd_fill(input logic [SDRAM_ADDR_W-1:0] a);
    sd_fill = {a[7:0], a[23:16]} ^ a[15:0];
  endfunction

  function automatic bf16_pkg::bf16_t make_bf16(input logic s, input logic [7:0] e,
                                                 input logic [6:0] fr);
    make_bf16.f.sign = s;
    make_bf16.f.exp  = e;
    make_bf16.f.frac = fr;
  endfunction

  function automatic bf16_pkg::bf16_t as_bf16(input logic [15:0] w);
    as_bf16.raw = w;
  endfunction

  function automatic bf16_pkg::bf16_t rand_bf16();
    rand_bf16 = make_bf16(1'($urandom), 8'($urandom_range(150, 100)), 7'($urandom));
  endfunction

  // Expected value from the arithmetic rules, 1.0 sits at bit 15 of mag
  function automatic bf16_pkg::bf16_t ref_result(input bf16_pkg::op_t op,
                                                  input bf16_pkg::bf16_t a,
                                                  input bf16_pkg::bf16_t b);
    logic [16:0]     ma;
    logic [16:0]     mb;
    logic [16:0]     mag;
    logic [15:0]     prod;
    logic            sb;
    logic            s;
    int              e;
    bf16_pkg::bf16_t r;
    ma = (a.f.exp == 8'd0) ? 17'd0 : {2'b01, a.f.frac, 8'h00};
    mb = (b.f.exp == 8'd0) ? 17'd0 : {2'b01, b.f.frac, 8'h00};
    if (op == bf16_pkg::OP_MUL) begin
      s    = a.f.sign ^ b.f.sign;
      e    = int'(a.f.exp) + int'(b.f.exp) - bf16_pkg::EXP_BIAS;
      prod = 16'(ma[15:8]) * 16'(mb[15:8]);
      mag  = {prod, 1'b0};  // 2.14 product
    end else begin
      sb = b.f.sign ^ (op == bf16_pkg::OP_SUB);
      if (a.f.exp >= b.f.exp) begin
        e  = int'(a.f.exp);
        mb = mb >> (a.f.exp - b.f.exp);
      end else begin
        e  = int'(b.f.exp);
        ma = ma >> (b.f.exp - a.f.exp);
      end
      if (a.f.sign == sb) begin
        mag = ma + mb;
        s   = sb;
      end else if (ma >= mb) begin
        mag = ma - mb;
        s   = a.f.sign;
      end else begin
        mag = mb - ma;
        s   = sb;
      end
      if (mag == 17'd0) begin
        s = 1'b0;
      end
    end
    if (mag != 17'd0) begin
      if (mag[16]) begin
        mag = mag >> 1;
        e   = e + 1;
      end
      while (!mag[15]) begin
        mag = mag << 1;
        e   = e - 1;
      end
    end
    r.f.sign = s;
    if (mag == 17'd0 || e < 1) begin
      r.f.exp  = 8'd0;
      r.f.frac = 7'd0;
    end else if (e > bf16_pkg::EXP_MAX - 1) begin
      r.f.exp  = 8'(bf16_pkg::EXP_MAX);
      r.f.frac = 7'd0;
    end else begin
      r.f.exp  = 8'(e);
      r.f.frac = mag[14:8];
    end
    return r;
  endfunction

  task automatic compare_bf16(input string name, input bf16_pkg::bf16_t got,
                              input bf16_pkg::bf16_t exp);
    check_count++;
    if (got.raw !== exp.raw) begin
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got.raw, exp.raw);
      err_count++;
    end
  endtask

  task automatic compare_status(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  // Holds the request until the DUT acknowledges it
  task automatic issue_request(input bf16_pkg::op_t op, input bf16_pkg::bf16_t a,
                               input bf16_pkg::bf16_t b, input logic [RAM_ADDR_W-1:0] ra,
                               input logic [SDRAM_ADDR_W-1:0] sa, input logic [15:0] sd);
    host_opcode     = op;
    host_data_a     = a;
    host_data_b     = b;
    host_ram_addr   = ra;
    host_sdram_addr = sa;
    host_sdram_data = sd;
    host_req        = 1'b1;
    @(negedge clk);
    while (!host_ack) begin
      @(negedge clk);
    end
    host_req = 1'b0;
  endtask

  task automatic expect_result(input bf16_pkg::bf16_t d, input logic st, input logic busy);
    exp_data_q.push_back(d);
    exp_status_q.push_back(st);
    exp_busy_q.push_back(busy);
  endtask

  // Queue drains every cycle, so an arithmetic response never sees host_busy
  task automatic send_arith(input bf16_pkg::op_t op, input bf16_pkg::bf16_t a,
                            input bf16_pkg::bf16_t b);
    expect_result(ref_result(op, a, b), 1'b0, 1'b0);
    issue_request(op, a, b, '0, '0, '0);
  endtask

  task automatic end_test(input string name, input int n_req);
    while (exp_data_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (6) @(negedge clk);  // Catch stray extra responses
    $display("test %s done: %0d requests, %0d errors", name, n_req,
             err_count - test_err_base);
    test_err_base = err_count;
    n_tests++;
  endtask

  // Response checker
  always @(negedge clk) begin
    if (!rst && host_resp_valid) begin
      if (exp_data_q.size() == 0) begin
        $display("Unexpected response at %0t with no request pending", $time);
        err_count++;
      end else begin
        compare_bf16("host_data_out", host_data_out, exp_data_q.pop_front());
        compare_status("host_op_status", host_op_status, exp_status_q.pop_front());
        compare_status("host_busy", host_busy, exp_busy_q.pop_front());
      end
    end
  end

  // Local RAM, read data valid by the next rising edge
  always @(negedge clk) begin
    if (ram_we) begin
      ram_mem[ram_addr] = ram_wdata;
    end
    ram_rdata = ram_mem.exists(ram_addr) ? ram_mem[ram_addr] : ram_fill(ram_addr);
  end

  // SDRAM with a random acknowledge delay
  always @(negedge clk) begin
    if (sdram_ack) begin
      sdram_ack = 1'b0;
    end else if (sdram_req) begin
      if (sd_delay == 0) begin
        sd_delay = int'($urandom_range(5, 1));
      end
      sd_delay--;
      if (sd_delay == 0) begin
        if (sdram_wr) begin
          sd_mem[sdram_addr] = sdram_wdata;
        end else begin
          sdram_rdata = sd_mem.exists(sdram_addr) ? sd_mem[sdram_addr] : sd_fill(sdram_addr);
        end
        sdram_ack = 1'b1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    bf16_pkg::bf16_t         a;
    bf16_pkg::bf16_t         b;
    logic [RAM_ADDR_W-1:0]   ra;
    logic [15:0]             w;
    logic [SDRAM_ADDR_W-1:0] sa_l [N_SD];
    logic [15:0]             sd_l [N_SD];
    logic [SDRAM_ADDR_W-1:0] sa;
    void'($urandom(32'h5060_2f56));
    rst             = 1'b1;
    host_req        = 1'b0;
    host_opcode     = '0;
    host_data_a     = '0;
    host_data_b     = '0;
    host_ram_addr   = '0;
    host_sdram_addr = '0;
    host_sdram_data = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < N_ADDSUB; i++) begin
      send_arith((i % 2 == 0) ? bf16_pkg::OP_ADD : bf16_pkg::OP_SUB, rand_bf16(), rand_bf16());
    end
    a = rand_bf16();
    send_arith(bf16_pkg::OP_SUB, a, a);  // Exact cancellation
    send_arith(bf16_pkg::OP_ADD, make_bf16(1'b0, 8'd0, 7'h11), a);
    send_arith(bf16_pkg::OP_ADD, a, make_bf16(~a.f.sign, a.f.exp, a.f.frac));
    end_test("add_sub", N_ADDSUB + 3);

    for (int i = 0; i < N_MUL; i++) begin
      send_arith(bf16_pkg::OP_MUL, rand_bf16(), rand_bf16());
    end
    send_arith(bf16_pkg::OP_MUL, make_bf16(1'b0, 8'd0, 7'h23), rand_bf16());
    send_arith(bf16_pkg::OP_MUL, rand_bf16(), make_bf16(1'b1, 8'd0, 7'h00));
    send_arith(bf16_pkg::OP_MUL, make_bf16(1'b1, 8'd10, 7'h05), make_bf16(1'b0, 8'd20, 7'h09));
    send_arith(bf16_pkg::OP_MUL, make_bf16(1'b1, 8'd200, 7'h01), make_bf16(1'b0, 8'd210, 7'h02));
    send_arith(bf16_pkg::OP_MUL, make_bf16(1'b0, 8'd190, 7'h7f), make_bf16(1'b0, 8'd191, 7'h7f));
    end_test("mul", N_MUL + 5);

    for (int i = 0; i < QUEUE_DEPTH + 2; i++) begin
      send_arith(bf16_pkg::op_t'(1 + i % 3), rand_bf16(), rand_bf16());
    end
    end_test("burst", QUEUE_DEPTH + 2);

    for (int i = 0; i < N_RAM; i++) begin
      ra = RAM_ADDR_W'($urandom_range(511, 0));
      w  = 16'($urandom);
      expect_result(as_bf16(16'h0000), 1'b0, 1'b1);
      issue_request(bf16_pkg::OP_RAM_WR, as_bf16(w), '0, ra, '0, '0);
      expect_result(as_bf16(w), 1'b0, 1'b1);
      issue_request(bf16_pkg::OP_RAM_RD, '0, '0, ra, '0, '0);
    end
    ra = RAM_ADDR_W'(10'h3ff);  // Never written
    expect_result(as_bf16(ram_fill(ra)), 1'b0, 1'b1);
    issue_request(bf16_pkg::OP_RAM_RD, '0, '0, ra, '0, '0);
    end_test("ram", 2 * N_RAM + 1);

    for (int i = 0; i < N_SD; i++) begin
      sa_l[i] = {1'b0, 4'(i), 19'($urandom)};  // Distinct addresses
      sd_l[i] = 16'($urandom);
      expect_result(as_bf16(16'h0000), 1'b0, 1'b1);
      issue_request(bf16_pkg::OP_SD_WR, '0, '0, '0, sa_l[i], sd_l[i]);
    end
    for (int i = 0; i < N_SD; i++) begin
      expect_result(as_bf16(sd_l[i]), 1'b0, 1'b1);
      issue_request(bf16_pkg::OP_SD_RD, '0, '0, '0, sa_l[i], '0);
    end
    sa = {1'b1, 23'($urandom)};
    expect_result(as_bf16(sd_fill(sa)), 1'b0, 1'b1);
    issue_request(bf16_pkg::OP_SD_RD, '0, '0, '0, sa, '0);
    end_test("sdram", 2 * N_SD + 1);

    foreach (sd_l[i]) begin
      if (i < 4) begin
        b = rand_bf16();
        expect_result(as_bf16(16'h0000), 1'b1, 1'b1);
        issue_request(bf16_pkg::op_t'((i == 0) ? 0 : (i == 1) ? 4 : (i == 2) ? 9 : 15),
                      rand_bf16(), b, '0, '0, 16'($urandom));
      end
    end
    end_test("invalid_op", 4);

    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/bf16_pkg.sv
verilog/bf16_arith_pipe.sv
verilog/bf16_arith_path.sv
verilog/mem_access.sv
verilog/host_response.sv
verilog/bf16_processor.sv
dv/tb_clock.sv
dv/bf16_processor_assert.sv
dv/bf16_processor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module bf16_processor_tb -o bf16_sim
./obj_dir/bf16_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
exit 1
